//--- all.f
+incdir+.
bus_pkg.sv
reg_pkg.sv
bus_interface.sv
host_regs.sv
vram.sv
host_port_top.sv
tb_host_port.sv

//--- Makefile
# Verilator build of the host port testbench
TOP := tb_host_port

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f all.f

# a failing test ends in $fatal, which gives a non-zero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_consts.svh"

module tb_host_port;

    localparam int RESET_CYC     = 4;
    localparam int CS_LOW_CYC    = 10;                  // host keeps select low this long
    localparam int CS_HIGH_CYC   = 4;                   // gap between accesses
    localparam int ACCESS_CYC    = CS_LOW_CYC + CS_HIGH_CYC;
    localparam int SCRATCH_WORDS = 4;
    localparam int BURST_WORDS   = 20;                  // long enough to wrap from the top
    // reset reads, scratch pairs, odd-byte cases, write burst, read burst
    localparam int N_ACCESS      = 30 + 4 * SCRATCH_WORDS + 9
                                   + (6 + 2 * BURST_WORDS) + (4 + 2 * BURST_WORDS);
    localparam int CYCLE_LIMIT   = (RESET_CYC + N_ACCESS * ACCESS_CYC) * 3 / 2;

    logic                       clk = 1'b0;
    logic                       reset_i;
    logic                       bus_cs_n_i;
    logic                       bus_rd_nwr_i;
    logic [3:0]                 bus_reg_num_i;
    logic                       bus_bytesel_i;
    logic [7:0]                 bus_data_i;
    logic [7:0]                 bus_data_o;

    logic [15:0]                lfsr_state = 16'd29;    // random source with a fixed seed
    int                         cycle_cnt  = 0;         // runaway guard

    logic [15:0]                m_vram [0:`VRAM_WORDS-1];   // model of the video RAM
    logic [`VRAM_ADDR_W-1:0]    m_addr;
    logic [15:0]                m_incr;
    logic [15:0]                m_scratch;
    logic [3:0]                 m_even_reg;             // register of the last even byte
    logic [7:0]                 m_even_data;

    logic [7:0]                 exp_q [$];              // expected bytes waiting for compare
    logic [7:0]                 act_q [$];              // bytes seen on bus_data_o
    string                      tag_q [$];
    logic [7:0]                 cmp_exp;
    logic [7:0]                 cmp_act;
    string                      cmp_tag;

    always #2 clk = ~clk;                               // 4 ns period

    host_port_top dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("TEST FAILED");
            $fatal(1, "timeout, the test did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    // pops one read sample per cycle and checks it
    always @(posedge clk) begin
        if (act_q.size() > 0) begin
            cmp_exp = exp_q.pop_front();
            cmp_act = act_q.pop_front();
            cmp_tag = tag_q.pop_front();
            check_byte(cmp_exp, cmp_act, cmp_tag);
        end
    end

    task automatic check_byte(input logic [7:0] expected, input logic [7:0] actual,
                              input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s, expected %02h got %02h", $time, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "read byte mismatch");
        end
    endtask

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[14:0], lfsr_state[0]};      // one step per bit taken
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // expected read byte from the model registers
    function automatic logic [7:0] expected_byte(input logic [3:0] reg_num, input logic bsel);
        logic [15:0] w;
        case (reg_num)
            `REG_ADDR:    w = {{(16-`VRAM_ADDR_W){1'b0}}, m_addr};
            `REG_INCR:    w = m_incr;
            `REG_DATA:    w = m_vram[m_addr];           // word at the current address
            `REG_SCRATCH: w = m_scratch;
            default:      w = `HOST_ID_WORD;
        endcase
        return bsel ? w[7:0] : w[15:8];                 // even byte is the high half
    endfunction

    task automatic advance_addr();
        m_addr = `VRAM_ADDR_W'((int'(m_addr) + int'(m_incr)) % `VRAM_WORDS);  // wraps at the top
    endtask

    task automatic model_write_byte(input logic [3:0] reg_num, input logic bsel,
                                    input logic [7:0] data);
        logic [15:0] w;
        if (!bsel) begin
            m_even_reg  = reg_num;                      // even byte only waits for its partner
            m_even_data = data;
        end else begin
            w = (reg_num == m_even_reg) ? {m_even_data, data} : {8'h00, data};
            case (reg_num)
                `REG_ADDR:    m_addr = w[`VRAM_ADDR_W-1:0];
                `REG_INCR:    m_incr = w;
                `REG_DATA: begin
                    m_vram[m_addr] = w;
                    advance_addr();
                end
                `REG_SCRATCH: m_scratch = w;
                default:      ;                         // id registers ignore writes
            endcase
        end
    endtask

    task automatic drive_pins(input bus_pkg::bus_sample_t s);
        bus_cs_n_i    <= s.cs ? bus_pkg::bus_cs_active : ~bus_pkg::bus_cs_active;
        bus_rd_nwr_i  <= s.rd;
        bus_reg_num_i <= s.reg_num;
        bus_bytesel_i <= s.bytesel;
        bus_data_i    <= s.data;
    endtask

    task automatic host_write_byte(input logic [3:0] reg_num, input logic bsel,
                                   input logic [7:0] data);
        bus_pkg::bus_sample_t s;
        s.cs      = 1'b1;
        s.rd      = 1'b0;
        s.reg_num = reg_num;
        s.bytesel = bsel;
        s.data    = data;
        @(posedge clk);
        drive_pins(s);                                  // all pins change with select
        repeat (CS_LOW_CYC) @(posedge clk);
        bus_cs_n_i <= ~bus_pkg::bus_cs_active;
        repeat (CS_HIGH_CYC - 1) @(posedge clk);
        model_write_byte(reg_num, bsel, data);
    endtask

    task automatic host_read_byte(input logic [3:0] reg_num, input logic bsel,
                                  output logic [7:0] act);
        bus_pkg::bus_sample_t s;
        s.cs      = 1'b1;
        s.rd      = 1'b1;
        s.reg_num = reg_num;
        s.bytesel = bsel;
        s.data    = 8'h00;
        @(posedge clk);
        drive_pins(s);
        repeat (CS_LOW_CYC - 2) @(posedge clk);
        @(negedge clk);                                 // middle of the ninth cycle
        act = bus_data_o;
        repeat (2) @(posedge clk);
        bus_cs_n_i <= ~bus_pkg::bus_cs_active;
        repeat (CS_HIGH_CYC - 1) @(posedge clk);
    endtask

    task automatic read_and_queue(input logic [3:0] reg_num, input logic bsel,
                                  input string what);
        logic [7:0] exp_b;
        logic [7:0] act_b;
        exp_b = expected_byte(reg_num, bsel);           // model state before the strobe
        host_read_byte(reg_num, bsel, act_b);
        exp_q.push_back(exp_b);
        act_q.push_back(act_b);
        tag_q.push_back(what);
        if (bsel && reg_num == `REG_DATA) begin
            advance_addr();                             // odd data read ends the word
        end
    endtask

    task automatic write_word(input logic [3:0] reg_num, input logic [15:0] w);
        host_write_byte(reg_num, 1'b0, w[15:8]);
        host_write_byte(reg_num, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input logic [3:0] reg_num, input string what);
        read_and_queue(reg_num, 1'b0, what);            // high byte first
        read_and_queue(reg_num, 1'b1, what);
    endtask

    initial begin : main_seq
        logic [7:0]              b;
        logic [`VRAM_ADDR_W-1:0] burst_start;
        logic [15:0]             burst_incr;

        reset_i       <= 1'b1;
        bus_cs_n_i    <= ~bus_pkg::bus_cs_active;
        bus_rd_nwr_i  <= 1'b0;
        bus_reg_num_i <= 4'd0;
        bus_bytesel_i <= 1'b0;
        bus_data_i    <= 8'h00;
        m_addr        = '0;
        m_incr        = '0;
        m_scratch     = '0;
        m_even_reg    = 4'd0;
        m_even_data   = 8'h00;
        repeat (RESET_CYC) @(posedge clk);
        reset_i <= 1'b0;

        read_word(`REG_ADDR, "ADDR after reset");
        read_word(`REG_INCR, "INCR after reset");
        read_word(`REG_SCRATCH, "SCRATCH after reset");
        for (int r = 4; r < 16; r++) begin
            read_word(4'(r), "id word");
        end

        for (int i = 0; i < SCRATCH_WORDS; i++) begin
            write_word(`REG_SCRATCH, rand_bits(16));
            read_word(`REG_SCRATCH, "SCRATCH byte pair");
        end

        // odd byte to another register than the buffered even byte
        b = 8'(rand_bits(8));
        host_write_byte(`REG_SCRATCH, 1'b0, b);
        b = 8'(rand_bits(8));
        host_write_byte(`REG_INCR, 1'b1, b);
        read_word(`REG_INCR, "INCR from unpaired odd byte");
        read_word(`REG_SCRATCH, "SCRATCH kept after even byte");
        b = 8'(rand_bits(8));
        host_write_byte(`REG_ADDR, 1'b1, b);            // lone odd byte
        read_word(`REG_ADDR, "ADDR from lone odd byte");

        // burst near the top of VRAM so the address wraps
        burst_start = `VRAM_ADDR_W'(16'h03F0 | rand_bits(4));
        burst_incr  = rand_bits(3);
        if (burst_incr == 16'd0) begin
            burst_incr = 16'd1;
        end
        write_word(`REG_ADDR, {{(16-`VRAM_ADDR_W){1'b0}}, burst_start});
        write_word(`REG_INCR, burst_incr);
        for (int k = 0; k < BURST_WORDS; k++) begin
            write_word(`REG_DATA, rand_bits(16));
        end
        read_word(`REG_ADDR, "ADDR after write burst");

        write_word(`REG_ADDR, {{(16-`VRAM_ADDR_W){1'b0}}, burst_start});
        for (int k = 0; k < BURST_WORDS; k++) begin
            read_word(`REG_DATA, "DATA read burst");
        end
        read_word(`REG_ADDR, "ADDR after read burst");

        repeat (2) @(posedge clk);                      // let the compare process drain
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- host_port_top.sv
`timescale 1ns/1ps
`default_nettype none

module host_port_top (
    input  wire logic           clk,                    // system clock
    input  wire logic           reset_i,                // synchronous reset
    input  wire logic           bus_cs_n_i,             // host select, active low
    input  wire logic           bus_rd_nwr_i,           // high for read
    input  wire logic [3:0]     bus_reg_num_i,          // host register number
    input  wire logic           bus_bytesel_i,          // low selects the even byte
    input  wire logic [7:0]     bus_data_i,             // host write data
    output logic      [7:0]     bus_data_o              // host read data
);

    reg_pkg::reg_cmd_t  cmd;                            // register command
    logic [15:0]        reg_rdata;                      // register read word
    reg_pkg::vram_req_t vram_req;                       // VRAM request
    logic [15:0]        vram_rdata;                     // VRAM read word

    // host pins to register commands
    bus_interface u_bus_interface (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .cmd_o          (cmd),
        .rdata_i        (reg_rdata)
    );

    // register file and data port
    host_regs u_host_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .cmd_i          (cmd),
        .rdata_o        (reg_rdata),
        .vram_req_o     (vram_req),
        .vram_rdata_i   (vram_rdata)
    );

    // video RAM behind the data port
    vram u_vram (
        .clk            (clk),
        .req_i          (vram_req),
        .rdata_o        (vram_rdata)
    );

endmodule

`default_nettype wire

//--- vram.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_consts.svh"

module vram (
    input  wire logic                   clk,            // system clock
    input  wire reg_pkg::vram_req_t     req_i,          // address, write enable and data
    output logic      [15:0]            rdata_o         // registered read word
);

    // word storage, contents are undefined after power up
    logic [`WORD_W-1:0] mem [0:`VRAM_WORDS-1];

    // single port, one access per cycle
    // a write also returns the new word, so the next read of that
    // address and the output agree
    always_ff @(posedge clk) begin
        if (req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
            rdata_o         <= req_i.wdata;             // write first
        end else begin
            rdata_o         <= mem[req_i.addr];         // one cycle read
        end
    end

endmodule

`default_nettype wire

//--- host_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_consts.svh"

module host_regs (
    input  wire logic                   clk,            // system clock
    input  wire logic                   reset_i,        // synchronous reset
    input  wire reg_pkg::reg_cmd_t      cmd_i,          // register command from bus_interface
    output logic      [15:0]            rdata_o,        // read word for cmd_i.reg_num
    output reg_pkg::vram_req_t          vram_req_o,     // request to vram
    input  wire logic [15:0]            vram_rdata_i    // vram word, one cycle after address
);

    logic [`VRAM_ADDR_W-1:0]    addr_r;                 // VRAM address register
    logic [`WORD_W-1:0]         incr_r;                 // address increment register
    logic [`WORD_W-1:0]         scratch_r;              // scratch register
    logic [`WORD_W-1:0]         data_latch;             // prefetched word at addr_r
    logic                       stale;                  // vram output still for the old address

    logic [`VRAM_ADDR_W-1:0]    addr_adv;               // address after one data access

    logic                       addr_wr;                // host writes ADDR
    logic                       incr_wr;                // host writes INCR
    logic                       scratch_wr;             // host writes SCRATCH
    logic                       data_wr;                // host writes DATA
    logic                       data_rd;                // host reads DATA
    logic                       addr_upd;               // address register changes this cycle

    // register decode of the strobes
    assign addr_wr    = cmd_i.wr & (cmd_i.reg_num == `REG_ADDR);
    assign incr_wr    = cmd_i.wr & (cmd_i.reg_num == `REG_INCR);
    assign scratch_wr = cmd_i.wr & (cmd_i.reg_num == `REG_SCRATCH);
    assign data_wr    = cmd_i.wr & (cmd_i.reg_num == `REG_DATA);
    assign data_rd    = cmd_i.rd & (cmd_i.reg_num == `REG_DATA);

    assign addr_upd   = addr_wr | data_wr | data_rd;

    // only the low address bits of the increment matter
    // the sum is cut to VRAM_ADDR_W bits, which wraps at VRAM_WORDS
    assign addr_adv   = addr_r + incr_r[`VRAM_ADDR_W-1:0];

    // vram always reads addr_r, a DATA write goes to the current address
    always_comb begin
        vram_req_o.we    = data_wr;
        vram_req_o.addr  = addr_r;
        vram_req_o.wdata = cmd_i.wdata;
    end

    // read word mux, combinational from the registers
    always_comb begin
        case (cmd_i.reg_num)
            `REG_ADDR:    rdata_o = {{(`WORD_W-`VRAM_ADDR_W){1'b0}}, addr_r};
            `REG_INCR:    rdata_o = incr_r;
            `REG_DATA:    rdata_o = data_latch;         // prefetched word
            `REG_SCRATCH: rdata_o = scratch_r;
            default:      rdata_o = `HOST_ID_WORD;      // registers 4 to 15
        endcase
    end

    // prefetch
    // the cycle after an address update the vram output still belongs to the old
    // address, the cycle after that it is the new word, so the latch is valid
    // two cycles after the change and keeps following vram while addr_r is stable
    always_ff @(posedge clk) begin
        if (!stale) begin
            data_latch <= vram_rdata_i;
        end

        if (reset_i) begin
            stale <= 1'b0;
        end else begin
            stale <= addr_upd;                          // one bit pending flag
        end
    end

    // host visible registers, updated the cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_r    <= '0;
            incr_r    <= '0;
            scratch_r <= '0;
        end else begin
            if (addr_wr) begin
                addr_r <= cmd_i.wdata[`VRAM_ADDR_W-1:0];    // upper bits ignored
            end else if (data_wr || data_rd) begin
                addr_r <= addr_adv;                     // auto increment on data access
            end

            if (incr_wr) begin
                incr_r <= cmd_i.wdata;
            end

            if (scratch_wr) begin
                scratch_r <= cmd_i.wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- bus_interface.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_consts.svh"

module bus_interface (
    input  wire logic                   clk,            // system clock, well above the bus rate
    input  wire logic                   reset_i,        // synchronous reset
    input  wire logic                   bus_cs_n_i,     // host select, active low
    input  wire logic                   bus_rd_nwr_i,   // high for read, low for write
    input  wire logic [3:0]             bus_reg_num_i,  // host register number
    input  wire logic                   bus_bytesel_i,  // low selects the even (high) byte
    input  wire logic [7:0]             bus_data_i,     // host write data
    output logic      [7:0]             bus_data_o,     // host read data
    output reg_pkg::reg_cmd_t           cmd_o,          // register command to host_regs
    input  wire logic [15:0]            rdata_i         // read word for cmd_o.reg_num
);

    // two stage synchronizer, s2 is the settled copy that is acted on
    bus_pkg::bus_sample_t   s1;                         // first stage, may be metastable
    bus_pkg::bus_sample_t   s2;                         // second stage

    logic [1:0]             sel_hist;                   // select history behind s2 for edge detect
    logic                   sel_rise;                   // select went active, bus settled

    logic                   wr_even;                    // even byte write seen this cycle
    logic                   wr_odd;                     // odd byte write seen this cycle
    logic                   rd_any;                     // read access seen this cycle

    logic [`REG_NUM_W-1:0]  even_reg;                   // register of the buffered even byte
    logic [`BYTE_W-1:0]     even_data;                  // buffered even byte
    logic [`WORD_W-1:0]     word;                       // word offered on an odd write

    logic                   rd_hold;                    // freeze read byte until select drops
    logic [`BYTE_W-1:0]     hold_byte;                  // byte captured at the read edge
    logic [`BYTE_W-1:0]     live_byte;                  // byte currently selected from rdata_i

    // rising edge one cycle after the synchronized select
    assign sel_rise  = sel_hist[1] & ~sel_hist[0];

    assign wr_even   = sel_rise & ~s2.rd & ~s2.bytesel;
    assign wr_odd    = sel_rise & ~s2.rd &  s2.bytesel;
    assign rd_any    = sel_rise &  s2.rd;

    // even byte goes out high, odd byte low
    assign live_byte = s2.bytesel ? rdata_i[7:0] : rdata_i[15:8];

    // during a read access the byte seen at the edge is kept, so the data port
    // advance and its prefetch cannot change what the host is sampling
    assign bus_data_o = rd_hold ? hold_byte : live_byte;

    // the even byte only joins the word when it went to the same register
    always_comb begin
        if (s2.reg_num == even_reg) begin
            word = {even_data, s2.data};                // full word
        end else begin
            word = {{`BYTE_W{1'b0}}, s2.data};          // odd byte alone, high half zero
        end
    end

    // pin synchronizers
    always_ff @(posedge clk) begin
        s1.cs      <= (bus_cs_n_i == bus_pkg::bus_cs_active);   // active high from here on
        s1.rd      <= bus_rd_nwr_i;
        s1.reg_num <= bus_reg_num_i;
        s1.bytesel <= bus_bytesel_i;
        s1.data    <= bus_data_i;
        s2         <= s1;

        if (reset_i) begin
            s1.cs    <= 1'b0;                           // no false select edge out of reset
            s2.cs    <= 1'b0;
            sel_hist <= 2'b00;
        end else begin
            sel_hist <= {s2.cs, sel_hist[1]};           // shift right, bit 0 is oldest
        end
    end

    // strobes, byte pairing and read byte hold
    always_ff @(posedge clk) begin
        if (wr_odd) begin
            cmd_o.wdata <= word;                        // qualified by cmd_o.wr
        end
        if (wr_even) begin
            even_data <= s2.data;
        end
        if (!rd_hold) begin
            hold_byte <= live_byte;                     // tracks until the read edge
        end

        if (reset_i) begin
            cmd_o.wr      <= 1'b0;
            cmd_o.rd      <= 1'b0;
            cmd_o.reg_num <= '0;
            even_reg      <= '0;
            rd_hold       <= 1'b0;
        end else begin
            cmd_o.wr      <= wr_odd;                    // one cycle pulse
            cmd_o.rd      <= rd_any & s2.bytesel;       // odd byte read ends the word
            cmd_o.reg_num <= s2.reg_num;                // follows the bus every cycle

            if (wr_even) begin
                even_reg <= s2.reg_num;
            end

            if (rd_any) begin
                rd_hold <= 1'b1;
            end else if (!sel_hist[1]) begin
                rd_hold <= 1'b0;                        // select gone, live byte again
            end
        end
    end

endmodule

`default_nettype wire

//--- reg_pkg.sv
`default_nettype none

`include "host_consts.svh"

// types on the register side of the port, between bus_interface, host_regs and vram
package reg_pkg;

    // register access command from bus_interface
    // wr and rd are single cycle strobes, reg_num is updated every cycle
    typedef struct packed {
        logic                   wr;             // word write strobe, odd byte access only
        logic                   rd;             // read strobe, odd byte access only
        logic [`REG_NUM_W-1:0]  reg_num;        // synchronized register number
        logic [`WORD_W-1:0]     wdata;          // joined even and odd bytes
    } reg_cmd_t;                                // 22 bits

    // single port VRAM request from host_regs
    typedef struct packed {
        logic                   we;             // write enable
        logic [`VRAM_ADDR_W-1:0] addr;          // word address, read every cycle
        logic [`WORD_W-1:0]     wdata;          // write word
    } vram_req_t;

endpackage

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

`include "host_consts.svh"

// types seen on the host bus side of bus_interface
package bus_pkg;

    // level of bus_cs_n_i when the port is selected
    localparam logic bus_cs_active = 1'b0;      // pin is active low

    // one registered copy of the five host inputs
    // select is turned active high when it is sampled
    typedef struct packed {
        logic                   cs;             // high while selected
        logic                   rd;             // high for a read access
        logic [`REG_NUM_W-1:0]  reg_num;        // register number
        logic                   bytesel;        // low for the even (high) byte
        logic [`BYTE_W-1:0]     data;           // write data byte
    } bus_sample_t;                             // 15 bits

endpackage

`default_nettype wire

//--- host_consts.svh
`ifndef HOST_CONSTS_SVH
`define HOST_CONSTS_SVH

// word and byte sizes on the register side
`define WORD_W          16              // register and VRAM word width
`define BYTE_W          8               // host data bus width
`define REG_NUM_W       4               // host register number width

// video RAM geometry
`define VRAM_ADDR_W     10              // VRAM word address bits
`define VRAM_WORDS      1024            // 2**VRAM_ADDR_W so the address wraps by truncation

// register map
`define REG_ADDR        4'd0            // VRAM address
`define REG_INCR        4'd1            // address increment after a data access
`define REG_DATA        4'd2            // VRAM data port
`define REG_SCRATCH     4'd3            // general purpose word
`define HOST_ID_WORD    16'hA5B1        // returned for registers 4 to 15

// depth of the host pin synchronizers in bus_interface, fixed at two stages
`define SYNC_STAGES     2

`endif
